/* design/mldsa_ntt_cfg.svh */
// ML-DSA INTT butterfly configuration
// Modulus, share width, random word count and pipeline depth

`ifndef MLDSA_NTT_CFG_SVH
`define MLDSA_NTT_CFG_SVH

// ML-DSA prime modulus, 2^23 - 2^13 + 1
`define MLDSA_Q 23'd8380417

// Width of one coefficient and of one additive share
`define COEFF_W 23

// Fresh random words consumed per accepted operation
`define RND_WORDS 5

// Cycles from valid_i to valid_o
// Stage 1 add/sub/refresh, 2-3 masked multiply, 4 unmask and halve
`define BF_LATENCY 4

`endif

/* design/masked_ntt_pkg.sv */
// Types and modular helpers shared by the masked INTT butterfly datapath
// and its control FSM

`default_nettype none

`include "mldsa_ntt_cfg.svh"

package masked_ntt_pkg;

    // One coefficient or one share, always kept reduced below Q
    typedef logic [`COEFF_W-1:0] coeff_t;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACTIVE = 2'd1,
        ST_CLEAR  = 2'd2
    } bf_ctrl_state_e;

    // (a + b) mod Q for reduced operands
    function automatic coeff_t add_mod(input coeff_t a, input coeff_t b);
        logic [`COEFF_W:0] sum;
        sum = a + b;
        // At most one subtraction needed
        if (sum >= `MLDSA_Q) begin
            sum = sum - `MLDSA_Q;
        end
        return sum[`COEFF_W-1:0];
    endfunction

    // (a - b) mod Q for reduced operands
    function automatic coeff_t sub_mod(input coeff_t a, input coeff_t b);
        logic [`COEFF_W:0] diff;
        // Bias by Q so the result never goes negative
        diff = {1'b0, a} + `MLDSA_Q - b;
        if (diff >= `MLDSA_Q) begin
            diff = diff - `MLDSA_Q;
        end
        return diff[`COEFF_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* design/masked_mod_mult.sv */
// Masked modular multiplier, two additive shares per operand
// Cross products in stage A, reduction and masked recombination in stage B

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module masked_mod_mult
    import masked_ntt_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic       clr_i,
    input  wire logic [1:0] en_i,
    input  wire coeff_t     a0_i,
    input  wire coeff_t     a1_i,
    input  wire coeff_t     b0_i,
    input  wire coeff_t     b1_i,
    input  wire coeff_t     rnd_i,
    output coeff_t          p0_o,
    output coeff_t          p1_o
);

    // Full width cross products
    logic [2*`COEFF_W-1:0] pr00_q, pr01_q, pr10_q, pr11_q;
    // Mask word travels with the products
    coeff_t rnd_q;
    // Reduced cross products
    coeff_t r00, r01, r10, r11;
    coeff_t p0_q, p1_q;

    // Stage A
    // Each product only mixes one share of a with one share of b
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pr00_q <= '0;
            pr01_q <= '0;
            pr10_q <= '0;
            pr11_q <= '0;
            rnd_q  <= '0;
        end else if (clr_i) begin
            pr00_q <= '0;
            pr01_q <= '0;
            pr10_q <= '0;
            pr11_q <= '0;
            rnd_q  <= '0;
        end else if (en_i[0]) begin
            pr00_q <= a0_i * b0_i;
            pr01_q <= a0_i * b1_i;
            pr10_q <= a1_i * b0_i;
            pr11_q <= a1_i * b1_i;
            rnd_q  <= rnd_i;
        end
    end

    // Reduce each product separately
    assign r00 = coeff_t'(pr00_q % `MLDSA_Q);
    assign r01 = coeff_t'(pr01_q % `MLDSA_Q);
    assign r10 = coeff_t'(pr10_q % `MLDSA_Q);
    assign r11 = coeff_t'(pr11_q % `MLDSA_Q);

    // Stage B
    // Mask enters each share before any sum could reveal a*b
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p0_q <= '0;
            p1_q <= '0;
        end else if (clr_i) begin
            p0_q <= '0;
            p1_q <= '0;
        end else if (en_i[1]) begin
            p0_q <= add_mod(add_mod(r00, rnd_q), r01);
            p1_q <= sub_mod(add_mod(r10, r11), rnd_q);
        end
    end

    assign p0_o = p0_q;
    assign p1_o = p1_q;

endmodule

`default_nettype wire

/* design/masked_gs_butterfly.sv */
// Masked Gentleman-Sande butterfly, three cycles
// Shares of u+v and of (u-v)*w, never combined inside

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module masked_gs_butterfly
    import masked_ntt_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   clr_i,
    input  wire logic [2:0]             en_i,
    input  wire coeff_t                 u0_i,
    input  wire coeff_t                 u1_i,
    input  wire coeff_t                 v0_i,
    input  wire coeff_t                 v1_i,
    input  wire coeff_t                 w0_i,
    input  wire coeff_t                 w1_i,
    input  wire coeff_t [`RND_WORDS-1:0] rnd_i,
    output coeff_t                      su0_o,
    output coeff_t                      su1_o,
    output coeff_t                      sv0_o,
    output coeff_t                      sv1_o
);

    // Refreshed input shares
    coeff_t u0_r, u1_r, v0_r, v1_r;
    // Stage 1 results
    coeff_t s0_q, s1_q, d0_q, d1_q, w0_q, w1_q, rnd4_q;
    // Sum shares delayed to meet the multiplier output
    coeff_t s0_d1_q, s1_d1_q, s0_d2_q, s1_d2_q;

    // Words 0 and 1 remask u and v before they are mixed
    assign u0_r = add_mod(u0_i, rnd_i[0]);
    assign u1_r = sub_mod(u1_i, rnd_i[0]);
    assign v0_r = add_mod(v0_i, rnd_i[1]);
    assign v1_r = sub_mod(v1_i, rnd_i[1]);

    // Stage 1, per share add and subtract
    // Words 2 and 3 remask the sum and the difference
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s0_q   <= '0;
            s1_q   <= '0;
            d0_q   <= '0;
            d1_q   <= '0;
            w0_q   <= '0;
            w1_q   <= '0;
            rnd4_q <= '0;
        end else if (clr_i) begin
            s0_q   <= '0;
            s1_q   <= '0;
            d0_q   <= '0;
            d1_q   <= '0;
            w0_q   <= '0;
            w1_q   <= '0;
            rnd4_q <= '0;
        end else if (en_i[0]) begin
            s0_q   <= add_mod(add_mod(u0_r, v0_r), rnd_i[2]);
            s1_q   <= sub_mod(add_mod(u1_r, v1_r), rnd_i[2]);
            d0_q   <= add_mod(sub_mod(u0_r, v0_r), rnd_i[3]);
            d1_q   <= sub_mod(sub_mod(u1_r, v1_r), rnd_i[3]);
            w0_q   <= w0_i;
            w1_q   <= w1_i;
            // Word 4 is kept for the multiplier mask
            rnd4_q <= rnd_i[4];
        end
    end

    // Stages 2 and 3, sum shares ride along
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s0_d1_q <= '0;
            s1_d1_q <= '0;
            s0_d2_q <= '0;
            s1_d2_q <= '0;
        end else if (clr_i) begin
            s0_d1_q <= '0;
            s1_d1_q <= '0;
            s0_d2_q <= '0;
            s1_d2_q <= '0;
        end else begin
            if (en_i[1]) begin
                s0_d1_q <= s0_q;
                s1_d1_q <= s1_q;
            end
            if (en_i[2]) begin
                s0_d2_q <= s0_d1_q;
                s1_d2_q <= s1_d1_q;
            end
        end
    end

    // (u - v) * w on shares
    masked_mod_mult i_masked_mod_mult (
        .clk     (clk),
        .reset_n (reset_n),
        .clr_i   (clr_i),
        .en_i    (en_i[2:1]),
        .a0_i    (d0_q),
        .a1_i    (d1_q),
        .b0_i    (w0_q),
        .b1_i    (w1_q),
        .rnd_i   (rnd4_q),
        .p0_o    (sv0_o),
        .p1_o    (sv1_o)
    );

    assign su0_o = s0_d2_q;
    assign su1_o = s1_d2_q;

endmodule

`default_nettype wire

/* design/share_unmask_div2.sv */
// Final stage: recombine the two shares of each result
// and halve modulo Q into the output register

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module share_unmask_div2
    import masked_ntt_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_n,
    input  wire logic   clr_i,
    input  wire logic   en_i,
    input  wire coeff_t su00_i,
    input  wire coeff_t su01_i,
    input  wire coeff_t sv00_i,
    input  wire coeff_t sv01_i,
    input  wire coeff_t su10_i,
    input  wire coeff_t su11_i,
    input  wire coeff_t sv10_i,
    input  wire coeff_t sv11_i,
    output coeff_t      u_out0_o,
    output coeff_t      v_out0_o,
    output coeff_t      u_out1_o,
    output coeff_t      v_out1_o
);

    // x / 2 mod Q; odd values borrow Q first to become even
    function automatic coeff_t half_mod(input coeff_t x);
        logic [`COEFF_W:0] t;
        t = x[0] ? ({1'b0, x} + `MLDSA_Q) : {1'b0, x};
        return t[`COEFF_W:1];
    endfunction

    // Only point where shares are added back together
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_out0_o <= '0;
            v_out0_o <= '0;
            u_out1_o <= '0;
            v_out1_o <= '0;
        end else if (clr_i) begin
            u_out0_o <= '0;
            v_out0_o <= '0;
            u_out1_o <= '0;
            v_out1_o <= '0;
        end else if (en_i) begin
            u_out0_o <= half_mod(add_mod(su00_i, su01_i));
            v_out0_o <= half_mod(add_mod(sv00_i, sv01_i));
            u_out1_o <= half_mod(add_mod(su10_i, su11_i));
            v_out1_o <= half_mod(add_mod(sv10_i, sv11_i));
        end
    end

endmodule

`default_nettype wire

/* design/masked_bf_ctrl.sv */
// Pipeline control for the masked butterfly pair
// Valid tracking, stage load enables, busy and zeroize sequencing

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module masked_bf_ctrl
    import masked_ntt_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  wire logic valid_i,
    input  wire logic zeroize_i,
    output logic [3:0] stage_en_o,
    output logic       clr_o,
    output logic       valid_o,
    output logic       busy_o
);

    bf_ctrl_state_e state_q, state_d;
    // Bit k set means stage k+1 holds a valid item
    logic [`BF_LATENCY-1:0] vld_q;
    logic [`BF_LATENCY-1:0] vld_d;

    // Clear holds for the zeroize level plus one cycle in ST_CLEAR
    assign clr_o = zeroize_i || (state_q == ST_CLEAR);

    // Shift in the new strobe, flush everything on clear
    assign vld_d = clr_o ? '0 : {vld_q[`BF_LATENCY-2:0], valid_i};

    // Stage k loads when its incoming item is valid
    assign stage_en_o = vld_d;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_q   <= '0;
            state_q <= ST_IDLE;
        end else begin
            vld_q   <= vld_d;
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (zeroize_i) begin
                    state_d = ST_CLEAR;
                end else if (|vld_d) begin
                    state_d = ST_ACTIVE;
                end
            end
            ST_ACTIVE: begin
                // Drop back once the last item has left
                if (zeroize_i) begin
                    state_d = ST_CLEAR;
                end else if (!(|vld_d)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_CLEAR: begin
                if (!zeroize_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // Nothing leaves while clearing
    assign valid_o = vld_q[`BF_LATENCY-1] && !clr_o;
    assign busy_o  = (state_q == ST_ACTIVE);

endmodule

`default_nettype wire

/* design/masked_intt_bf1x2.sv */
// First masked INTT stage: two shared GS butterflies, then
// share recombination and halving; fixed 4-cycle pipeline

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module masked_intt_bf1x2
    import masked_ntt_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   valid_i,
    input  wire logic                   zeroize_i,
    // Butterfly 0 operands, two shares each
    input  wire coeff_t                 u00_i,
    input  wire coeff_t                 u01_i,
    input  wire coeff_t                 v00_i,
    input  wire coeff_t                 v01_i,
    input  wire coeff_t                 w00_i,
    input  wire coeff_t                 w01_i,
    // Butterfly 1 operands
    input  wire coeff_t                 u10_i,
    input  wire coeff_t                 u11_i,
    input  wire coeff_t                 v10_i,
    input  wire coeff_t                 v11_i,
    input  wire coeff_t                 w10_i,
    input  wire coeff_t                 w11_i,
    input  wire coeff_t [`RND_WORDS-1:0] rnd_i,
    output logic                        valid_o,
    output logic                        busy_o,
    output coeff_t                      u_out0_o,
    output coeff_t                      v_out0_o,
    output coeff_t                      u_out1_o,
    output coeff_t                      v_out1_o
);

    logic [3:0] stage_en;
    logic       clr;
    coeff_t     su00, su01, sv00, sv01;
    coeff_t     su10, su11, sv10, sv11;

    masked_bf_ctrl i_masked_bf_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .valid_i    (valid_i),
        .zeroize_i  (zeroize_i),
        .stage_en_o (stage_en),
        .clr_o      (clr),
        .valid_o    (valid_o),
        .busy_o     (busy_o)
    );

    // Butterfly 0 takes the random words in order
    masked_gs_butterfly i_masked_gs_butterfly0 (
        .clk     (clk),
        .reset_n (reset_n),
        .clr_i   (clr),
        .en_i    (stage_en[2:0]),
        .u0_i    (u00_i),
        .u1_i    (u01_i),
        .v0_i    (v00_i),
        .v1_i    (v01_i),
        .w0_i    (w00_i),
        .w1_i    (w01_i),
        .rnd_i   (rnd_i),
        .su0_o   (su00),
        .su1_o   (su01),
        .sv0_o   (sv00),
        .sv1_o   (sv01)
    );

    // Butterfly 1 sees them rotated by one word
    masked_gs_butterfly i_masked_gs_butterfly1 (
        .clk     (clk),
        .reset_n (reset_n),
        .clr_i   (clr),
        .en_i    (stage_en[2:0]),
        .u0_i    (u10_i),
        .u1_i    (u11_i),
        .v0_i    (v10_i),
        .v1_i    (v11_i),
        .w0_i    (w10_i),
        .w1_i    (w11_i),
        .rnd_i   ({rnd_i[0], rnd_i[`RND_WORDS-1:1]}),
        .su0_o   (su10),
        .su1_o   (su11),
        .sv0_o   (sv10),
        .sv1_o   (sv11)
    );

    share_unmask_div2 i_share_unmask_div2 (
        .clk      (clk),
        .reset_n  (reset_n),
        .clr_i    (clr),
        .en_i     (stage_en[3]),
        .su00_i   (su00),
        .su01_i   (su01),
        .sv00_i   (sv00),
        .sv01_i   (sv01),
        .su10_i   (su10),
        .su11_i   (su11),
        .sv10_i   (sv10),
        .sv11_i   (sv11),
        .u_out0_o (u_out0_o),
        .v_out0_o (v_out0_o),
        .u_out1_o (u_out1_o),
        .v_out1_o (v_out1_o)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock and power-on reset
// 10 unit clock period, reset_n held low for the first 16 cycles

`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Release lands on a rising edge, like any other driven input
    initial begin
        reset_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tests/masked_intt_bf1x2_checker.sv */
// Bound protocol checks for the masked INTT butterfly pair
// Output valid latency, zeroize drop window and busy tracking

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module masked_intt_bf1x2_checker (
    input wire logic clk,
    input wire logic reset_n,
    input wire logic valid_i,
    input wire logic zeroize_i,
    input wire logic valid_o,
    input wire logic busy_o
);

    // Edges since zeroize_i was last sampled high, saturating
    logic [3:0] zero_age_q;
    // Shadow of the accepted items still inside the pipeline
    logic [`BF_LATENCY-1:0] flight_q;
    // Clear is the zeroize level plus the cycle right after it
    logic clr_win;
    int unsigned fail_count = 0;

    assign clr_win = zeroize_i || (zero_age_q == 4'd0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            zero_age_q <= 4'hf;
            flight_q   <= '0;
        end else begin
            if (zeroize_i) begin
                zero_age_q <= 4'd0;
            end else if (zero_age_q != 4'hf) begin
                zero_age_q <= zero_age_q + 4'd1;
            end
            flight_q <= clr_win ? '0 : {flight_q[`BF_LATENCY-2:0], valid_i};
        end
    end

    // Every output pulse traces back to a strobe BF_LATENCY cycles earlier
    a_valid_origin: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |-> $past(valid_i, `BF_LATENCY))
        else begin
            $error("valid_o without a valid_i BF_LATENCY cycles before");
            fail_count++;
        end

    // A strobe with no clear in its window must come out
    a_valid_arrives: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(valid_i, `BF_LATENCY) && !zeroize_i && (zero_age_q > `BF_LATENCY))
        |-> valid_o)
        else begin
            $error("valid_i did not produce valid_o after BF_LATENCY cycles");
            fail_count++;
        end

    // Nothing may emerge shortly after zeroize
    a_zeroize_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |-> (!zeroize_i && (zero_age_q >= `BF_LATENCY)))
        else begin
            $error("valid_o inside the zeroize window");
            fail_count++;
        end

    a_busy_flight: assert property (@(posedge clk) disable iff (!reset_n)
        (|flight_q) |-> busy_o)
        else begin
            $error("busy_o low while an item is in flight");
            fail_count++;
        end

endmodule

bind masked_intt_bf1x2 masked_intt_bf1x2_checker i_checker (
    .clk       (clk),
    .reset_n   (reset_n),
    .valid_i   (valid_i),
    .zeroize_i (zeroize_i),
    .valid_o   (valid_o),
    .busy_o    (busy_o)
);

`default_nettype wire

/* tests/masked_intt_bf1x2_tb.sv */
// Testbench for the masked INTT butterfly pair
// Random, mask, burst, edge and zeroize traffic against a modular reference

`default_nettype none

`include "mldsa_ntt_cfg.svh"

module masked_intt_bf1x2_tb
    import masked_ntt_pkg::*;
();

    localparam longint unsigned Q = 64'(`MLDSA_Q);
    // Inverse of 2 modulo Q
    localparam longint unsigned INV2 = (Q + 64'd1) / 64'd2;
    localparam int N_SINGLE = 40;
    localparam int N_MASK_SETS = 6;
    localparam int N_MASK_SPLITS = 3;
    localparam int N_BURST = 30;
    localparam int N_EDGE = 18;
    localparam int N_ZERO_PRE = 8;
    localparam int N_ZERO_POST = 6;
    localparam int TOTAL_OPS = N_SINGLE + N_MASK_SETS * N_MASK_SPLITS + N_BURST
                             + N_EDGE + N_ZERO_PRE + N_ZERO_POST;
    // Spaced ops cost about BF_LATENCY plus four cycles each
    localparam int WATCHDOG_CYCLES = 16 + TOTAL_OPS * (`BF_LATENCY + 4) + 200;

    typedef struct packed {
        coeff_t u0;
        coeff_t v0;
        coeff_t u1;
        coeff_t v1;
    } result_t;

    logic clk;
    logic reset_n;
    logic valid_i;
    logic zeroize_i;
    coeff_t u00_i, u01_i, v00_i, v01_i, w00_i, w01_i;
    coeff_t u10_i, u11_i, v10_i, v11_i, w10_i, w11_i;
    coeff_t [`RND_WORDS-1:0] rnd_i;
    logic valid_o;
    logic busy_o;
    coeff_t u_out0_o, v_out0_o, u_out1_o, v_out1_o;

    // Expected results in issue order
    result_t exp_q[$];
    result_t last_res;
    logic [31:0] lcg_state = 32'd75;
    string test_name = "reset";
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned base_errors = 0;
    int unsigned cycle_cnt = 0;
    int unsigned vo_count = 0;
    int unsigned first_vo = 0;
    int unsigned last_vo = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    masked_intt_bf1x2 i_masked_intt_bf1x2 (
        .clk       (clk),
        .reset_n   (reset_n),
        .valid_i   (valid_i),
        .zeroize_i (zeroize_i),
        .u00_i     (u00_i),
        .u01_i     (u01_i),
        .v00_i     (v00_i),
        .v01_i     (v01_i),
        .w00_i     (w00_i),
        .w01_i     (w01_i),
        .u10_i     (u10_i),
        .u11_i     (u11_i),
        .v10_i     (v10_i),
        .v11_i     (v11_i),
        .w10_i     (w10_i),
        .w11_i     (w11_i),
        .rnd_i     (rnd_i),
        .valid_o   (valid_o),
        .busy_o    (busy_o),
        .u_out0_o  (u_out0_o),
        .v_out0_o  (v_out0_o),
        .u_out1_o  (u_out1_o),
        .v_out1_o  (v_out1_o)
    );

    // One LCG step reduced below Q
    function automatic coeff_t rand_coeff();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return coeff_t'(64'(lcg_state >> 8) % Q);
    endfunction

    // Second share so that both add up to x mod Q
    function automatic coeff_t other_share(input coeff_t x, input coeff_t s0);
        return coeff_t'((64'(x) + Q - 64'(s0)) % Q);
    endfunction

    // Halving done as a multiply by the inverse of 2
    function automatic coeff_t model_sum(input coeff_t u, input coeff_t v);
        longint unsigned x;
        x = (64'(u) + 64'(v)) % Q;
        return coeff_t'((x * INV2) % Q);
    endfunction

    function automatic coeff_t model_diff(input coeff_t u, input coeff_t v, input coeff_t w);
        longint unsigned x;
        x = (64'(u) + Q - 64'(v)) % Q;
        x = (x * 64'(w)) % Q;
        return coeff_t'((x * INV2) % Q);
    endfunction

    task automatic check_value(input string what, input longint unsigned exp_v,
                               input longint unsigned act_v);
        checks++;
        assert (act_v == exp_v)
        else begin
            $display("FAILED %s %s: expected %0d actual %0d", test_name, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        base_errors = errors;
    endtask

    task automatic finish_test();
        $display("test %s done, %0d errors", test_name, errors - base_errors);
    endtask

    // Split values into shares, draw fresh masks, queue the model result
    task automatic issue_op(input coeff_t u0, input coeff_t v0, input coeff_t w0,
                            input coeff_t u1, input coeff_t v1, input coeff_t w1);
        coeff_t s [6];
        result_t exp_r;
        int k;
        for (k = 0; k < 6; k++) begin
            s[k] = rand_coeff();
        end
        exp_r.u0 = model_sum(u0, v0);
        exp_r.v0 = model_diff(u0, v0, w0);
        exp_r.u1 = model_sum(u1, v1);
        exp_r.v1 = model_diff(u1, v1, w1);
        @(posedge clk);
        valid_i <= 1'b1;
        u00_i <= s[0];
        u01_i <= other_share(u0, s[0]);
        v00_i <= s[1];
        v01_i <= other_share(v0, s[1]);
        w00_i <= s[2];
        w01_i <= other_share(w0, s[2]);
        u10_i <= s[3];
        u11_i <= other_share(u1, s[3]);
        v10_i <= s[4];
        v11_i <= other_share(v1, s[4]);
        w10_i <= s[5];
        w11_i <= other_share(w1, s[5]);
        for (k = 0; k < `RND_WORDS; k++) begin
            rnd_i[k] <= rand_coeff();
        end
        exp_q.push_back(exp_r);
    endtask

    task automatic end_strobe();
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    // Waits until every queued result has come out
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic single_op(input coeff_t u0, input coeff_t v0, input coeff_t w0,
                             input coeff_t u1, input coeff_t v1, input coeff_t w1);
        issue_op(u0, v0, w0, u1, v1, w1);
        end_strobe();
        drain();
    endtask

    task automatic random_op();
        coeff_t r [6];
        int k;
        for (k = 0; k < 6; k++) begin
            r[k] = rand_coeff();
        end
        issue_op(r[0], r[1], r[2], r[3], r[4], r[5]);
    endtask

    // Same values with new shares and masks each time
    task automatic mask_set();
        coeff_t r [6];
        result_t exp_r;
        int k;
        for (k = 0; k < 6; k++) begin
            r[k] = rand_coeff();
        end
        exp_r.u0 = model_sum(r[0], r[1]);
        exp_r.v0 = model_diff(r[0], r[1], r[2]);
        exp_r.u1 = model_sum(r[3], r[4]);
        exp_r.v1 = model_diff(r[3], r[4], r[5]);
        for (k = 0; k < N_MASK_SPLITS; k++) begin
            single_op(r[0], r[1], r[2], r[3], r[4], r[5]);
            check_value("u_out0 across masks", exp_r.u0, last_res.u0);
            check_value("v_out0 across masks", exp_r.v0, last_res.v0);
            check_value("u_out1 across masks", exp_r.u1, last_res.u1);
            check_value("v_out1 across masks", exp_r.v1, last_res.v1);
        end
    endtask

    // Sums of 1 and Q-2 are odd, sums of 0 and Q-1 even
    task automatic edge_ops();
        coeff_t e [3];
        coeff_t w [2];
        int i;
        int j;
        int k;
        e[0] = '0;
        e[1] = 23'd1;
        e[2] = coeff_t'(Q - 64'd1);
        w[0] = 23'd1;
        w[1] = coeff_t'(Q - 64'd1);
        for (i = 0; i < 3; i++) begin
            for (j = 0; j < 3; j++) begin
                for (k = 0; k < 2; k++) begin
                    single_op(e[i], e[j], w[k], e[j], e[i], w[1-k]);
                end
            end
        end
    endtask

    task automatic zeroize_run();
        int k;
        int unsigned dropped;
        for (k = 0; k < N_ZERO_PRE; k++) begin
            random_op();
        end
        @(posedge clk);
        valid_i   <= 1'b0;
        zeroize_i <= 1'b1;
        // One edge later the last BF_LATENCY items are gone
        @(posedge clk);
        dropped = exp_q.size();
        exp_q.delete();
        check_value("dropped items", `BF_LATENCY, dropped);
        @(posedge clk);
        zeroize_i <= 1'b0;
        // Clear holds one more cycle after the level falls
        repeat (2) @(posedge clk);
        check_value("u_out0 cleared", 0, u_out0_o);
        check_value("v_out0 cleared", 0, v_out0_o);
        check_value("u_out1 cleared", 0, u_out1_o);
        check_value("v_out1 cleared", 0, v_out1_o);
        check_value("busy_o after zeroize", 0, busy_o);
        for (k = 0; k < N_ZERO_POST; k++) begin
            random_op();
        end
        end_strobe();
        drain();
    endtask

    // Result monitor compares each output pulse with the oldest expectation
    always @(posedge clk) begin : monitor
        result_t exp_r;
        if (reset_n && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %s: valid_o with no operation outstanding", test_name);
                errors++;
            end else begin
                exp_r = exp_q.pop_front();
                check_value("u_out0", exp_r.u0, u_out0_o);
                check_value("v_out0", exp_r.v0, v_out0_o);
                check_value("u_out1", exp_r.u1, u_out1_o);
                check_value("v_out1", exp_r.v1, v_out1_o);
                last_res = {u_out0_o, v_out0_o, u_out1_o, v_out1_o};
            end
            vo_count++;
            last_vo = cycle_cnt;
            if (vo_count == 1) begin
                first_vo = cycle_cnt;
            end
        end
        cycle_cnt++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: results still missing after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        valid_i   = 1'b0;
        zeroize_i = 1'b0;
        {u00_i, u01_i, v00_i, v01_i, w00_i, w01_i} = '0;
        {u10_i, u11_i, v10_i, v11_i, w10_i, w11_i} = '0;
        rnd_i     = '0;

        start_test("reset");
        @(posedge reset_n);
        @(posedge clk);
        check_value("valid_o", 0, valid_o);
        check_value("busy_o", 0, busy_o);
        check_value("u_out0", 0, u_out0_o);
        check_value("v_out0", 0, v_out0_o);
        check_value("u_out1", 0, u_out1_o);
        check_value("v_out1", 0, v_out1_o);
        finish_test();

        start_test("random_single");
        repeat (N_SINGLE) begin
            random_op();
            end_strobe();
            drain();
        end
        finish_test();

        start_test("mask_independence");
        repeat (N_MASK_SETS) mask_set();
        finish_test();

        start_test("back_to_back");
        vo_count = 0;
        repeat (N_BURST) random_op();
        end_strobe();
        drain();
        check_value("pulse count", N_BURST, vo_count);
        check_value("pulse span", N_BURST - 1, last_vo - first_vo);
        finish_test();

        start_test("edge_operands");
        edge_ops();
        finish_test();

        start_test("zeroize");
        zeroize_run();
        finish_test();

        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, i_masked_intt_bf1x2.i_checker.fail_count);
        if (errors == 0 && i_masked_intt_bf1x2.i_checker.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/masked_ntt_pkg.sv
design/masked_mod_mult.sv
design/masked_gs_butterfly.sv
design/share_unmask_div2.sv
design/masked_bf_ctrl.sv
design/masked_intt_bf1x2.sv
tests/tb_clock_gen.sv
tests/masked_intt_bf1x2_checker.sv
tests/masked_intt_bf1x2_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := masked_intt_bf1x2_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_ARGS  := +verilator+error+limit+1000
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
